//--- common/drone_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Flight control core shared types, word widths, gains and limits
////////////////////////////////////////////////////////////////////////////

package drone_pkg;

    // Datapath word widths
    localparam int ANGLE_WIDTH    = 16;
    localparam int RATE_WIDTH     = 16;
    localparam int MOTOR_WIDTH    = 8;
    localparam int THROTTLE_WIDTH = 8;

    // Mixer sum width, throttle plus three corrections
    localparam int MIX_WIDTH = RATE_WIDTH + 2;

    // Euler angle or angle target, IMU units
    typedef logic signed [ANGLE_WIDTH-1:0] angle_t;

    // Angular rate for targets, gyro readings and corrections
    typedef logic signed [RATE_WIDTH-1:0] rate_t;

    // Motor rate, legal range 0 to MOTOR_MAX
    typedef logic [MOTOR_WIDTH-1:0] motor_t;

    // Throttle stick value
    typedef logic [THROTTLE_WIDTH-1:0] throttle_t;

    // Proportional gains as right shifts
    localparam int ANGLE_SHIFT = 2;
    localparam int RATE_SHIFT  = 3;

    // Per-axis correction magnitude bound
    localparam int CORR_LIMIT = 64;

    // Highest motor rate the ESC accepts
    localparam int MOTOR_MAX = 250;

    // PWM period in sys_clk cycles
    localparam int PWM_PERIOD    = 256;
    localparam int PWM_CNT_WIDTH = $clog2(PWM_PERIOD);

endpackage

//--- hw/flight_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// Flight sequencer: four-phase sample handshake, one stage strobe per cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module flight_sequencer (
    input  logic sys_clk,
    input  logic resetn,
    input  logic sample_req,
    output logic sample_ack,
    output logic capture,
    output logic angle_start,
    output logic rate_start,
    output logic mix_start,
    output logic commit
);

    // State names the strobe issued on the next edge
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ANGLE,
        ST_RATE,
        ST_MIX,
        ST_ACK,
        ST_RELEASE
    } state_t;

    state_t state;

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            state       <= ST_IDLE;
            sample_ack  <= 1'b0;
            capture     <= 1'b0;
            angle_start <= 1'b0;
            rate_start  <= 1'b0;
            mix_start   <= 1'b0;
            commit      <= 1'b0;
        end else begin
            // Strobes last one cycle
            capture     <= 1'b0;
            angle_start <= 1'b0;
            rate_start  <= 1'b0;
            mix_start   <= 1'b0;
            commit      <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // New sample, inputs already stable
                    if (sample_req) begin
                        capture <= 1'b1;
                        state   <= ST_ANGLE;
                    end
                end
                ST_ANGLE: begin
                    angle_start <= 1'b1;
                    state       <= ST_RATE;
                end
                ST_RATE: begin
                    rate_start <= 1'b1;
                    state      <= ST_MIX;
                end
                ST_MIX: begin
                    mix_start <= 1'b1;
                    state     <= ST_ACK;
                end
                ST_ACK: begin
                    // Motor rates registered this edge
                    commit     <= 1'b1;
                    sample_ack <= 1'b1;
                    state      <= ST_RELEASE;
                end
                ST_RELEASE: begin
                    // Hold ack until source drops req
                    if (!sample_req) begin
                        sample_ack <= 1'b0;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Ack only answers a live request
    assert property (@(posedge sys_clk) disable iff (!resetn)
        $rose(sample_ack) |-> sample_req);

    // One stage active per cycle
    assert property (@(posedge sys_clk) disable iff (!resetn)
        $onehot0({capture, angle_start, rate_start, mix_start, commit}));

endmodule

//--- hw/angle_controller.sv
////////////////////////////////////////////////////////////////////////////
// Angle stage: roll and pitch angle errors to rate targets, P only
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module angle_controller (
    input  logic                sys_clk,
    input  logic                resetn,
    input  logic                capture,
    input  logic                angle_start,
    input  drone_pkg::throttle_t throttle,
    input  drone_pkg::angle_t   roll_target,
    input  drone_pkg::angle_t   pitch_target,
    input  drone_pkg::angle_t   roll_angle,
    input  drone_pkg::angle_t   pitch_angle,
    input  drone_pkg::rate_t    yaw_rate_target,
    output drone_pkg::rate_t    roll_rate_target,
    output drone_pkg::rate_t    pitch_rate_target,
    output drone_pkg::rate_t    yaw_rate_out,
    output drone_pkg::throttle_t throttle_out
);

    import drone_pkg::*;

    // Sample held for the whole handshake
    throttle_t throttle_q;
    angle_t    roll_target_q;
    angle_t    pitch_target_q;
    angle_t    roll_angle_q;
    angle_t    pitch_angle_q;
    rate_t     yaw_rate_q;

    // Guard bit so the error cannot wrap
    logic signed [ANGLE_WIDTH:0] roll_err;
    logic signed [ANGLE_WIDTH:0] pitch_err;

    always_ff @(posedge sys_clk) begin
        if (capture) begin
            throttle_q     <= throttle;
            roll_target_q  <= roll_target;
            pitch_target_q <= pitch_target;
            roll_angle_q   <= roll_angle;
            pitch_angle_q  <= pitch_angle;
            yaw_rate_q     <= yaw_rate_target;
        end
    end

    assign roll_err  = roll_target_q - roll_angle_q;
    assign pitch_err = pitch_target_q - pitch_angle_q;

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            roll_rate_target  <= '0;
            pitch_rate_target <= '0;
            yaw_rate_out      <= '0;
            throttle_out      <= '0;
        end else if (angle_start) begin
            // Shift gain, result fits back in one word
            roll_rate_target  <= rate_t'(roll_err >>> ANGLE_SHIFT);
            pitch_rate_target <= rate_t'(pitch_err >>> ANGLE_SHIFT);
            // Yaw target already a rate
            yaw_rate_out      <= yaw_rate_q;
            throttle_out      <= throttle_q;
        end
    end

endmodule

//--- hw/rate_controller.sv
////////////////////////////////////////////////////////////////////////////
// Rate stage: saturated proportional corrections on roll, pitch and yaw
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rate_controller (
    input  logic             sys_clk,
    input  logic             resetn,
    input  logic             capture,
    input  logic             rate_start,
    input  drone_pkg::rate_t roll_gyro,
    input  drone_pkg::rate_t pitch_gyro,
    input  drone_pkg::rate_t yaw_gyro,
    input  drone_pkg::rate_t roll_rate_target,
    input  drone_pkg::rate_t pitch_rate_target,
    input  drone_pkg::rate_t yaw_rate_target,
    output drone_pkg::rate_t roll_corr,
    output drone_pkg::rate_t pitch_corr,
    output drone_pkg::rate_t yaw_corr
);

    import drone_pkg::*;

    // Gyro readings of the current sample
    rate_t roll_gyro_q;
    rate_t pitch_gyro_q;
    rate_t yaw_gyro_q;

    // Scaled rate errors, one guard bit
    logic signed [RATE_WIDTH:0] roll_err;
    logic signed [RATE_WIDTH:0] pitch_err;
    logic signed [RATE_WIDTH:0] yaw_err;

    // Clip to +/- CORR_LIMIT
    function automatic rate_t saturate(input logic signed [RATE_WIDTH:0] value);
        if (value > CORR_LIMIT) begin
            return rate_t'(CORR_LIMIT);
        end else if (value < -CORR_LIMIT) begin
            return rate_t'(-CORR_LIMIT);
        end
        return rate_t'(value);
    endfunction

    always_ff @(posedge sys_clk) begin
        if (capture) begin
            roll_gyro_q  <= roll_gyro;
            pitch_gyro_q <= pitch_gyro;
            yaw_gyro_q   <= yaw_gyro;
        end
    end

    assign roll_err  = (roll_rate_target - roll_gyro_q) >>> RATE_SHIFT;
    assign pitch_err = (pitch_rate_target - pitch_gyro_q) >>> RATE_SHIFT;
    assign yaw_err   = (yaw_rate_target - yaw_gyro_q) >>> RATE_SHIFT;

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            roll_corr  <= '0;
            pitch_corr <= '0;
            yaw_corr   <= '0;
        end else if (rate_start) begin
            roll_corr  <= saturate(roll_err);
            pitch_corr <= saturate(pitch_err);
            yaw_corr   <= saturate(yaw_err);
        end
    end

    // Mixer headroom relies on this bound
    assert property (@(posedge sys_clk) disable iff (!resetn)
        (roll_corr <= CORR_LIMIT) && (roll_corr >= -CORR_LIMIT) &&
        (pitch_corr <= CORR_LIMIT) && (pitch_corr >= -CORR_LIMIT) &&
        (yaw_corr <= CORR_LIMIT) && (yaw_corr >= -CORR_LIMIT));

endmodule

//--- hw/motor_mixer.sv
////////////////////////////////////////////////////////////////////////////
// Quad-X motor mixer with clamping and arm gating
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module motor_mixer (
    input  logic                 sys_clk,
    input  logic                 resetn,
    input  logic                 capture,
    input  logic                 mix_start,
    input  logic                 arm,
    input  drone_pkg::throttle_t throttle,
    input  drone_pkg::rate_t     roll_corr,
    input  drone_pkg::rate_t     pitch_corr,
    input  drone_pkg::rate_t     yaw_corr,
    output drone_pkg::motor_t    motor_1_rate,
    output drone_pkg::motor_t    motor_2_rate,
    output drone_pkg::motor_t    motor_3_rate,
    output drone_pkg::motor_t    motor_4_rate
);

    import drone_pkg::*;

    logic arm_q;

    // Throttle as a signed operand
    logic signed [MIX_WIDTH-1:0] thr_s;
    logic signed [MIX_WIDTH-1:0] sum_1, sum_2, sum_3, sum_4;

    function automatic motor_t clamp_motor(input logic signed [MIX_WIDTH-1:0] value);
        if (value < 0) begin
            return '0;
        end else if (value > MOTOR_MAX) begin
            return motor_t'(MOTOR_MAX);
        end
        return motor_t'(value);
    endfunction

    assign thr_s = MIX_WIDTH'(throttle);

    // Front pair on +pitch, left pair on +roll, CW props on -yaw
    assign sum_1 = thr_s + pitch_corr + roll_corr - yaw_corr;
    assign sum_2 = thr_s + pitch_corr - roll_corr + yaw_corr;
    assign sum_3 = thr_s - pitch_corr - roll_corr - yaw_corr;
    assign sum_4 = thr_s - pitch_corr + roll_corr + yaw_corr;

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            arm_q        <= 1'b0;
            motor_1_rate <= '0;
            motor_2_rate <= '0;
            motor_3_rate <= '0;
            motor_4_rate <= '0;
        end else begin
            // Arm sampled with the rest of the request
            if (capture) begin
                arm_q <= arm;
            end
            if (mix_start) begin
                motor_1_rate <= arm_q ? clamp_motor(sum_1) : '0;
                motor_2_rate <= arm_q ? clamp_motor(sum_2) : '0;
                motor_3_rate <= arm_q ? clamp_motor(sum_3) : '0;
                motor_4_rate <= arm_q ? clamp_motor(sum_4) : '0;
            end
        end
    end

    // ESC range never exceeded
    assert property (@(posedge sys_clk) disable iff (!resetn)
        (motor_1_rate <= MOTOR_MAX) && (motor_2_rate <= MOTOR_MAX) &&
        (motor_3_rate <= MOTOR_MAX) && (motor_4_rate <= MOTOR_MAX));

endmodule

//--- hw/pwm_generator.sv
////////////////////////////////////////////////////////////////////////////
// Four-channel ESC PWM, duty update aligned to the period boundary
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pwm_generator (
    input  logic              sys_clk,
    input  logic              resetn,
    input  logic              commit,
    input  drone_pkg::motor_t motor_1_rate,
    input  drone_pkg::motor_t motor_2_rate,
    input  drone_pkg::motor_t motor_3_rate,
    input  drone_pkg::motor_t motor_4_rate,
    output logic              motor_1_pwm,
    output logic              motor_2_pwm,
    output logic              motor_3_pwm,
    output logic              motor_4_pwm
);

    import drone_pkg::*;

    logic [PWM_CNT_WIDTH-1:0] pwm_cnt;
    logic                     period_end;
    motor_t                   rate_in [4];
    motor_t                   pending_duty [4];
    motor_t                   active_duty [4];
    logic [3:0]               pwm_out;

    assign rate_in[0] = motor_1_rate;
    assign rate_in[1] = motor_2_rate;
    assign rate_in[2] = motor_3_rate;
    assign rate_in[3] = motor_4_rate;

    assign period_end = (pwm_cnt == PWM_CNT_WIDTH'(PWM_PERIOD - 1));

    // Free running period counter
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            pwm_cnt <= '0;
        end else if (period_end) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    // Pending on commit, active only at wrap so no runt pulses
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            pending_duty <= '{default: '0};
            active_duty  <= '{default: '0};
        end else begin
            if (commit) begin
                pending_duty <= rate_in;
            end
            if (period_end) begin
                active_duty <= pending_duty;
            end
        end
    end

    // High for duty cycles from counter zero
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            pwm_out[i] = (pwm_cnt < active_duty[i]);
        end
    end

    assign motor_1_pwm = pwm_out[0];
    assign motor_2_pwm = pwm_out[1];
    assign motor_3_pwm = pwm_out[2];
    assign motor_4_pwm = pwm_out[3];

endmodule

//--- hw/flight_core.sv
////////////////////////////////////////////////////////////////////////////
// Flight control core top: sequencer, control stages, mixer and PWM
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module flight_core (
    input  logic                 sys_clk,
    input  logic                 resetn,
    input  logic                 sample_req,
    output logic                 sample_ack,
    input  logic                 arm,
    input  drone_pkg::throttle_t throttle,
    input  drone_pkg::angle_t    roll_target,
    input  drone_pkg::angle_t    pitch_target,
    input  drone_pkg::rate_t     yaw_rate_target,
    input  drone_pkg::angle_t    roll_angle,
    input  drone_pkg::angle_t    pitch_angle,
    input  drone_pkg::rate_t     roll_gyro,
    input  drone_pkg::rate_t     pitch_gyro,
    input  drone_pkg::rate_t     yaw_gyro,
    output logic                 motor_1_pwm,
    output logic                 motor_2_pwm,
    output logic                 motor_3_pwm,
    output logic                 motor_4_pwm
);

    import drone_pkg::*;

    // Stage strobes
    logic capture, angle_start, rate_start, mix_start, commit;

    // Angle stage to rate stage
    rate_t     roll_rate_target, pitch_rate_target, yaw_rate_out;
    throttle_t throttle_out;

    // Rate stage to mixer
    rate_t roll_corr, pitch_corr, yaw_corr;

    // Mixer to PWM
    motor_t motor_1_rate, motor_2_rate, motor_3_rate, motor_4_rate;

    flight_sequencer u_sequencer (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .sample_req  (sample_req),
        .sample_ack  (sample_ack),
        .capture     (capture),
        .angle_start (angle_start),
        .rate_start  (rate_start),
        .mix_start   (mix_start),
        .commit      (commit)
    );

    angle_controller u_angle (
        .sys_clk           (sys_clk),
        .resetn            (resetn),
        .capture           (capture),
        .angle_start       (angle_start),
        .throttle          (throttle),
        .roll_target       (roll_target),
        .pitch_target      (pitch_target),
        .roll_angle        (roll_angle),
        .pitch_angle       (pitch_angle),
        .yaw_rate_target   (yaw_rate_target),
        .roll_rate_target  (roll_rate_target),
        .pitch_rate_target (pitch_rate_target),
        .yaw_rate_out      (yaw_rate_out),
        .throttle_out      (throttle_out)
    );

    rate_controller u_rate (
        .sys_clk           (sys_clk),
        .resetn            (resetn),
        .capture           (capture),
        .rate_start        (rate_start),
        .roll_gyro         (roll_gyro),
        .pitch_gyro        (pitch_gyro),
        .yaw_gyro          (yaw_gyro),
        .roll_rate_target  (roll_rate_target),
        .pitch_rate_target (pitch_rate_target),
        .yaw_rate_target   (yaw_rate_out),
        .roll_corr         (roll_corr),
        .pitch_corr        (pitch_corr),
        .yaw_corr          (yaw_corr)
    );

    motor_mixer u_mixer (
        .sys_clk      (sys_clk),
        .resetn       (resetn),
        .capture      (capture),
        .mix_start    (mix_start),
        .arm          (arm),
        .throttle     (throttle_out),
        .roll_corr    (roll_corr),
        .pitch_corr   (pitch_corr),
        .yaw_corr     (yaw_corr),
        .motor_1_rate (motor_1_rate),
        .motor_2_rate (motor_2_rate),
        .motor_3_rate (motor_3_rate),
        .motor_4_rate (motor_4_rate)
    );

    pwm_generator u_pwm (
        .sys_clk      (sys_clk),
        .resetn       (resetn),
        .commit       (commit),
        .motor_1_rate (motor_1_rate),
        .motor_2_rate (motor_2_rate),
        .motor_3_rate (motor_3_rate),
        .motor_4_rate (motor_4_rate),
        .motor_1_pwm  (motor_1_pwm),
        .motor_2_pwm  (motor_2_pwm),
        .motor_3_pwm  (motor_3_pwm),
        .motor_4_pwm  (motor_4_pwm)
    );

endmodule

//--- verification/flight_checker.sv
////////////////////////////////////////////////////////////////////////////
// Flight core checker with handshake monitor and PWM pulse width compare
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module flight_checker (
    input  logic              sys_clk,
    input  logic              resetn,
    input  logic              sample_req,
    input  logic              sample_ack,
    input  logic              motor_1_pwm,
    input  logic              motor_2_pwm,
    input  logic              motor_3_pwm,
    input  logic              motor_4_pwm,
    input  drone_pkg::motor_t exp_rate_1,
    input  drone_pkg::motor_t exp_rate_2,
    input  drone_pkg::motor_t exp_rate_3,
    input  drone_pkg::motor_t exp_rate_4,
    output int                checks_done,
    output int                pass_count,
    output int                fail_count
);

    import drone_pkg::*;

    localparam int RESET_TIMEOUT = 100;
    localparam int ACK_TIMEOUT   = 20000;
    localparam int ALIGN_TIMEOUT = 2 * PWM_PERIOD;

    // Expected PWM counter value from reset
    logic [PWM_CNT_WIDTH-1:0] phase;
    logic [3:0]               pwm;
    logic                     ack_q;
    int                       req_cycles;
    int                       proto_errors;
    int                       expected [4];
    int                       high_cnt [4];
    int                       ack_high_cnt;

    assign pwm = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            phase <= '0;
        end else if (phase == PWM_PERIOD - 1) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // Handshake rules with req counted in cycles seen high
    always @(negedge sys_clk) begin
        if (!resetn) begin
            ack_q        <= 1'b0;
            req_cycles   <= 0;
            proto_errors <= 0;
        end else begin
            ack_q      <= sample_ack;
            req_cycles <= sample_req ? req_cycles + 1 : 0;
            // Ack due 4 cycles after req first seen
            if (sample_ack && !ack_q && !(sample_req && req_cycles == 4)) begin
                $display("CHECK FAILED at %0t: sample_ack rose out of step", $time);
                proto_errors <= proto_errors + 1;
            end
            // Ack held for as long as req stays high
            if (ack_q && !sample_ack && sample_req) begin
                $display("CHECK FAILED at %0t: sample_ack fell while req high", $time);
                proto_errors <= proto_errors + 1;
            end
            // Gone by the first cycle of low req
            if (sample_ack && !sample_req) begin
                $display("CHECK FAILED at %0t: sample_ack high after req fell", $time);
                proto_errors <= proto_errors + 1;
            end
        end
    end

    task automatic wait_period_start(output bit found);
        int waited;
        waited = 0;
        found  = 1'b0;
        while (!found && waited < ALIGN_TIMEOUT) begin
            @(negedge sys_clk);
            waited++;
            found = (phase == '0);
        end
    endtask

    // One sample per negedge over phases 0 to PWM_PERIOD-1
    task automatic measure_period();
        for (int m = 0; m < 4; m++) begin
            high_cnt[m] = 0;
        end
        for (int c = 0; c < PWM_PERIOD; c++) begin
            for (int m = 0; m < 4; m++) begin
                high_cnt[m] += pwm[m];
            end
            ack_high_cnt += sample_ack;
            @(negedge sys_clk);
        end
    endtask

    task automatic finish_test(input bit ok, input int errs_before);
        bit failed;
        failed = !ok || (proto_errors != errs_before);
        for (int m = 0; m < 4; m++) begin
            if (ok && high_cnt[m] != expected[m]) begin
                $display("CHECK FAILED at %0t: test %0d motor %0d high %0d cycles, expected %0d",
                         $time, checks_done, m + 1, high_cnt[m], expected[m]);
                failed = 1'b1;
            end
        end
        if (failed) begin
            fail_count++;
        end else begin
            pass_count++;
        end
        $display("Test %0d %s", checks_done, failed ? "failed" : "passed");
        checks_done++;
    endtask

    initial begin
        int waited;
        bit found;
        int errs_before;
        checks_done  = 0;
        pass_count   = 0;
        fail_count   = 0;
        ack_high_cnt = 0;
        waited       = 0;
        @(negedge sys_clk);
        while (resetn !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(negedge sys_clk);
            waited++;
        end
        // Test 0 checks idle outputs after reset
        for (int m = 0; m < 4; m++) begin
            expected[m] = 0;
        end
        errs_before = proto_errors;
        wait_period_start(found);
        if (found) begin
            measure_period();
        end else begin
            $display("No PWM period start found within two periods after reset");
        end
        if (ack_high_cnt != 0) begin
            $display("sample_ack was high during the first period after reset");
        end
        finish_test(found && ack_high_cnt == 0, errs_before);

        forever begin
            waited = 0;
            while (!sample_ack && waited < ACK_TIMEOUT) begin
                @(negedge sys_clk);
                waited++;
            end
            if (!sample_ack) begin
                $display("No sample_ack seen within %0d cycles", ACK_TIMEOUT);
                continue;
            end
            expected[0] = exp_rate_1;
            expected[1] = exp_rate_2;
            expected[2] = exp_rate_3;
            expected[3] = exp_rate_4;
            errs_before = proto_errors;
            // Pending duties load on the edge after commit
            @(negedge sys_clk);
            wait_period_start(found);
            if (found) begin
                measure_period();
            end else begin
                $display("No PWM period start found within two periods after ack");
            end
            finish_test(found, errs_before);
        end
    end

endmodule

//--- verification/tb_flight_core.sv
////////////////////////////////////////////////////////////////////////////
// Flight core testbench with a file-driven four-phase sample source
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_flight_core;

    import drone_pkg::*;

    localparam int RESET_CYCLES  = 10;
    localparam int ACK_TIMEOUT   = 64;
    localparam int CHECK_TIMEOUT = 4 * PWM_PERIOD;
    localparam int NUM_FIELDS    = 14;
    localparam     STIM_FILE     = "verification/flight_stimulus.txt";

    logic      sys_clk;
    logic      resetn;
    logic      sample_req;
    logic      sample_ack;
    logic      arm;
    throttle_t throttle;
    angle_t    roll_target;
    angle_t    pitch_target;
    rate_t     yaw_rate_target;
    angle_t    roll_angle;
    angle_t    pitch_angle;
    rate_t     roll_gyro;
    rate_t     pitch_gyro;
    rate_t     yaw_gyro;
    logic      motor_1_pwm;
    logic      motor_2_pwm;
    logic      motor_3_pwm;
    logic      motor_4_pwm;
    motor_t    exp_rate_1;
    motor_t    exp_rate_2;
    motor_t    exp_rate_3;
    motor_t    exp_rate_4;
    int        checks_done;
    int        pass_count;
    int        fail_count;

    // One stimulus line in file column order
    int                 f [NUM_FIELDS];
    logic [8*256-1:0]   line_buf;
    logic [31:0]        rng_state;

    flight_core u_dut (
        .sys_clk         (sys_clk),
        .resetn          (resetn),
        .sample_req      (sample_req),
        .sample_ack      (sample_ack),
        .arm             (arm),
        .throttle        (throttle),
        .roll_target     (roll_target),
        .pitch_target    (pitch_target),
        .yaw_rate_target (yaw_rate_target),
        .roll_angle      (roll_angle),
        .pitch_angle     (pitch_angle),
        .roll_gyro       (roll_gyro),
        .pitch_gyro      (pitch_gyro),
        .yaw_gyro        (yaw_gyro),
        .motor_1_pwm     (motor_1_pwm),
        .motor_2_pwm     (motor_2_pwm),
        .motor_3_pwm     (motor_3_pwm),
        .motor_4_pwm     (motor_4_pwm)
    );

    flight_checker u_checker (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .sample_req  (sample_req),
        .sample_ack  (sample_ack),
        .motor_1_pwm (motor_1_pwm),
        .motor_2_pwm (motor_2_pwm),
        .motor_3_pwm (motor_3_pwm),
        .motor_4_pwm (motor_4_pwm),
        .exp_rate_1  (exp_rate_1),
        .exp_rate_2  (exp_rate_2),
        .exp_rate_3  (exp_rate_3),
        .exp_rate_4  (exp_rate_4),
        .checks_done (checks_done),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    initial sys_clk = 1'b0;
    always #4 sys_clk = ~sys_clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Inputs settle one cycle before req and hold until ack drops
    task automatic run_sample(input int hold_cycles, output bit ok);
        int waited;
        @(negedge sys_clk);
        arm             <= (f[0] != 0);
        throttle        <= throttle_t'(f[1]);
        roll_target     <= angle_t'(f[2]);
        pitch_target    <= angle_t'(f[3]);
        yaw_rate_target <= rate_t'(f[4]);
        roll_angle      <= angle_t'(f[5]);
        pitch_angle     <= angle_t'(f[6]);
        roll_gyro       <= rate_t'(f[7]);
        pitch_gyro      <= rate_t'(f[8]);
        yaw_gyro        <= rate_t'(f[9]);
        exp_rate_1      <= motor_t'(f[10]);
        exp_rate_2      <= motor_t'(f[11]);
        exp_rate_3      <= motor_t'(f[12]);
        exp_rate_4      <= motor_t'(f[13]);
        @(negedge sys_clk);
        sample_req <= 1'b1;
        waited = 0;
        while (!sample_ack && waited < ACK_TIMEOUT) begin
            @(negedge sys_clk);
            waited++;
        end
        ok = sample_ack;
        // Source keeps req high a little longer
        repeat (hold_cycles) @(negedge sys_clk);
        sample_req <= 1'b0;
        waited = 0;
        while (sample_ack && waited < ACK_TIMEOUT) begin
            @(negedge sys_clk);
            waited++;
        end
        ok = ok && !sample_ack;
    endtask

    task automatic wait_checks(input int target, output bit ok);
        int waited;
        waited = 0;
        while (checks_done < target && waited < CHECK_TIMEOUT) begin
            @(negedge sys_clk);
            waited++;
        end
        ok = (checks_done >= target);
    endtask

    initial begin
        bit ok;
        bit aborted;
        int fd;
        int code;
        int num_tests;
        int hold;
        resetn          = 1'b0;
        sample_req      = 1'b0;
        arm             = 1'b0;
        throttle        = '0;
        roll_target     = '0;
        pitch_target    = '0;
        yaw_rate_target = '0;
        roll_angle      = '0;
        pitch_angle     = '0;
        roll_gyro       = '0;
        pitch_gyro      = '0;
        yaw_gyro        = '0;
        exp_rate_1      = '0;
        exp_rate_2      = '0;
        exp_rate_3      = '0;
        exp_rate_4      = '0;
        rng_state       = 32'd35476;
        aborted         = 1'b0;
        num_tests       = 0;
        hold            = 0;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        @(negedge sys_clk);
        resetn <= 1'b1;

        wait_checks(1, ok);
        if (!ok) begin
            $display("Timeout: idle check after reset did not finish");
            aborted = 1'b1;
        end
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            code = 0;
            if ($fgets(line_buf, fd) != 0) begin
                code = $sscanf(line_buf, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                               f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                               f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
            end
            // Comment and blank lines scan short
            if (code == NUM_FIELDS) begin
                num_tests++;
                rng_state = next_random(rng_state);
                repeat (rng_state % 8) @(negedge sys_clk);
                rng_state = next_random(rng_state);
                hold = 1 + int'(rng_state % 4);
                run_sample(hold, ok);
                if (!ok) begin
                    $display("Timeout: four-phase handshake stalled on test %0d", num_tests);
                    aborted = 1'b1;
                end else begin
                    wait_checks(num_tests + 1, ok);
                    if (!ok) begin
                        $display("Timeout: PWM check of test %0d did not finish", num_tests);
                        aborted = 1'b1;
                    end
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (aborted || num_tests == 0 || fail_count != 0 || u_checker.proto_errors != 0) begin
            $display("Checks failed");
        end else begin
            $display("All checks passed");
        end
        $finish;
    end

endmodule

//--- verification/flight_stimulus.txt
# arm throttle roll_tgt pitch_tgt yaw_rate_tgt roll_ang pitch_ang roll_gyro pitch_gyro yaw_gyro
# then expected motor rates m1 m2 m3 m4, all decimal
1 100 0 0 0 0 0 0 0 0 100 100 100 100
1 128 256 0 0 0 0 0 0 0 136 120 120 136
1 120 0 -320 0 0 0 0 0 0 110 110 130 130
1 90 0 0 0 100 0 15 0 0 85 95 95 85
1 100 0 0 200 0 0 0 0 40 80 120 80 120
1 100 8000 0 0 0 0 0 0 0 164 36 36 164
1 100 0 -10000 0 0 0 0 0 0 36 36 164 164
1 150 0 0 0 0 0 1000 0 0 86 214 214 86
1 245 256 256 0 0 0 0 0 0 250 245 229 245
1 10 -256 -256 0 0 0 0 0 0 0 10 26 10
0 150 400 -200 0 0 0 0 0 0 0 0 0 0
1 200 0 0 0 0 0 0 0 0 200 200 200 200
1 60 40 -30 -50 -8 2 -4 8 6 67 49 67 57
1 0 0 0 0 0 0 0 0 0 0 0 0 0
1 250 0 0 0 0 0 0 0 0 250 250 250 250
1 50 -1 0 0 0 0 0 0 0 49 51 51 49

//--- sources.f
common/drone_pkg.sv
hw/flight_sequencer.sv
hw/angle_controller.sv
hw/rate_controller.sv
hw/motor_mixer.sv
hw/pwm_generator.sv
hw/flight_core.sv
verification/flight_checker.sv
verification/tb_flight_core.sv

//--- Bender.yml
package:
  name: flight_core

sources:
  - common/drone_pkg.sv
  - hw/flight_sequencer.sv
  - hw/angle_controller.sv
  - hw/rate_controller.sv
  - hw/motor_mixer.sv
  - hw/pwm_generator.sv
  - hw/flight_core.sv
  - target: test
    files:
      - verification/flight_checker.sv
      - verification/tb_flight_core.sv
